//--- rtl/rv_ctrl_pkg.sv
// ==============================
// RV32I control encodings only. No CSR, fence or system opcodes.
// Field widths are fixed by the base ISA.
// ==============================
`default_nettype none

package rv_ctrl_pkg;

  localparam int XLEN     = 32;
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;
  localparam int IMM12_W  = 12;
  // rd, rs1 and rs2 share what is left of the R-format word
  localparam int REG_W    = (XLEN - FUNCT7_W - FUNCT3_W - OPCODE_W) / 3;

  localparam int IMM_SRA_BIT = 10;  // Bit 30 of the word, inside imm12

  // Major opcodes
  localparam logic [OPCODE_W-1:0] OPC_RTYPE  = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OPC_ITYPE  = 7'b0010011;
  localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
  localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
  localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPCODE_W-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPCODE_W-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [OPCODE_W-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;

  // Arithmetic funct3
  localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
  localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101;  // srl and sra
  localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

  // Load funct3
  localparam logic [FUNCT3_W-1:0] F3_LB  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_LH  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_LW  = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_LBU = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_LHU = 3'b101;

  // Unsigned branch funct3
  localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

  localparam logic [FUNCT7_W-1:0] F7_ALT = 7'b0100000;  // sub and sra

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_MEM,
    WB_ALU,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [2:0] {
    LD_W,
    LD_HU,
    LD_H,
    LD_BU,
    LD_B
  } ld_sel_e;

  typedef enum logic {
    PC_PLUS4,
    PC_JUMP
  } pc_sel_e;

  typedef struct packed {
    logic [FUNCT7_W-1:0] funct7;
    logic [REG_W-1:0]    rs2;
    logic [REG_W-1:0]    rs1;
    logic [FUNCT3_W-1:0] funct3;
    logic [REG_W-1:0]    rd;
    logic [OPCODE_W-1:0] opcode;
  } rv_rfmt_t;

  typedef struct packed {
    logic [IMM12_W-1:0]  imm12;
    logic [REG_W-1:0]    rs1;
    logic [FUNCT3_W-1:0] funct3;
    logic [REG_W-1:0]    rd;
    logic [OPCODE_W-1:0] opcode;
  } rv_ifmt_t;

  // One instruction word, two field views
  typedef union packed {
    rv_rfmt_t rfmt;
    rv_ifmt_t ifmt;
  } rv_instr_u;

  typedef struct packed {
    alu_op_e alu_op;
    logic    a_pc;   // Operand A is the PC
    logic    b_imm;  // Operand B is the immediate
    logic    br_un;  // Unsigned branch compare
  } ex_ctrl_t;

  typedef struct packed {
    logic    rf_we;
    wb_sel_e wb_sel;
    ld_sel_e ld_sel;
    pc_sel_e pc_sel;
  } wb_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/ex_ctrl_stage.sv
// ==============================
// Execute-stage control register and decode.
// Stall holds the stage; a strobe offered during a stall is lost.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   in_valid,
  input  rv_ctrl_pkg::rv_instr_u in_instr,
  output logic                   ex_valid,
  output rv_ctrl_pkg::rv_instr_u ex_instr,
  output rv_ctrl_pkg::ex_ctrl_t  ex_ctrl
);

  import rv_ctrl_pkg::*;

  logic      valid_q;
  rv_instr_u instr_q;

  logic      is_rtype;
  logic      alt_r;     // funct7 marks sub or sra
  logic      alt_i;     // imm12 marks srai
  logic      sub_en;
  logic      sra_en;
  alu_op_e   arith_op;
  ex_ctrl_t  dec;

  // Stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      instr_q <= in_instr;  // Payload only
    end
  end

  // The R view is read for register ops, the I view for OP-IMM
  assign is_rtype = (instr_q.rfmt.opcode == OPC_RTYPE);
  assign alt_r    = (instr_q.rfmt.funct7 == F7_ALT);
  assign alt_i    = instr_q.ifmt.imm12[IMM_SRA_BIT];

  assign sub_en = is_rtype & alt_r;         // No subi in RV32I
  assign sra_en = is_rtype ? alt_r : alt_i;

  // Shared funct3 decode for register and immediate ops
  always_comb begin
    case (instr_q.ifmt.funct3)
      F3_ADD: begin
        arith_op = sub_en ? ALU_SUB : ALU_ADD;
      end
      F3_SLL:  arith_op = ALU_SLL;
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      F3_SR: begin
        arith_op = sra_en ? ALU_SRA : ALU_SRL;
      end
      F3_OR:   arith_op = ALU_OR;
      F3_AND:  arith_op = ALU_AND;
      default: arith_op = ALU_ADD;
    endcase
  end

  // Per-opcode operand selects
  always_comb begin
    dec        = '0;
    dec.alu_op = ALU_ADD;  // Address and pass-through ops add
    case (instr_q.rfmt.opcode)
      OPC_RTYPE: begin
        dec.alu_op = arith_op;
      end
      OPC_ITYPE: begin
        dec.alu_op = arith_op;
        dec.b_imm  = 1'b1;
      end
      OPC_LOAD, OPC_STORE, OPC_LUI: begin
        dec.b_imm = 1'b1;  // Base plus offset, or imm alone
      end
      OPC_JAL, OPC_AUIPC: begin
        dec.a_pc  = 1'b1;
        dec.b_imm = 1'b1;
      end
      OPC_BRANCH: begin
        dec.br_un = (instr_q.ifmt.funct3 == F3_BLTU) ||
                    (instr_q.ifmt.funct3 == F3_BGEU);
      end
      default: begin
        dec.alu_op = ALU_ADD;  // JALR and unknown opcodes
      end
    endcase
  end

  assign ex_valid = valid_q;
  assign ex_instr = instr_q;
  assign ex_ctrl  = valid_q ? dec : '0;  // Zero when no instruction

endmodule

`default_nettype wire

//--- rtl/wb_ctrl_stage.sv
// ==============================
// Writeback-stage control register and decode.
// Branches are not resolved here and always select PC+4.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module wb_ctrl_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   ex_valid,
  input  rv_ctrl_pkg::rv_instr_u ex_instr,
  output logic                   wb_valid,
  output rv_ctrl_pkg::wb_ctrl_t  wb_ctrl
);

  import rv_ctrl_pkg::*;

  logic      valid_q;
  rv_instr_u instr_q;
  ld_sel_e   ld_dec;
  wb_ctrl_t  dec;

  // Stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      instr_q <= ex_instr;
    end
  end

  // Load extension from funct3
  always_comb begin
    case (instr_q.ifmt.funct3)
      F3_LB:   ld_dec = LD_B;
      F3_LH:   ld_dec = LD_H;
      F3_LW:   ld_dec = LD_W;
      F3_LBU:  ld_dec = LD_BU;
      F3_LHU:  ld_dec = LD_HU;
      default: ld_dec = LD_W;  // Reserved load width
    endcase
  end

  always_comb begin
    dec        = '0;
    dec.wb_sel = WB_MEM;
    dec.ld_sel = LD_W;
    dec.pc_sel = PC_PLUS4;
    case (instr_q.ifmt.opcode)
      OPC_RTYPE, OPC_ITYPE, OPC_AUIPC, OPC_LUI: begin
        dec.rf_we  = 1'b1;
        dec.wb_sel = WB_ALU;
      end
      OPC_LOAD: begin
        dec.rf_we  = 1'b1;
        dec.wb_sel = WB_MEM;
        dec.ld_sel = ld_dec;
      end
      OPC_JAL, OPC_JALR: begin
        dec.rf_we  = 1'b1;
        dec.wb_sel = WB_PC4;   // Link address
        dec.pc_sel = PC_JUMP;
      end
      default: begin
        dec.rf_we = 1'b0;  // Stores, branches, unknown
      end
    endcase
  end

  assign wb_valid = valid_q;
  assign wb_ctrl  = valid_q ? dec : '0;

endmodule

`default_nettype wire

//--- rtl/rv_ctrl_pipe.sv
// ==============================
// Two-stage RV32I control pipeline, no handshake.
// in_valid is a strobe; hold the word through a stall.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_pipe (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   in_valid,
  input  rv_ctrl_pkg::rv_instr_u in_instr,
  output logic                   ex_valid,
  output rv_ctrl_pkg::ex_ctrl_t  ex_ctrl,
  output logic                   wb_valid,
  output rv_ctrl_pkg::wb_ctrl_t  wb_ctrl
);

  import rv_ctrl_pkg::*;

  rv_instr_u ex_instr;  // Word held in the execute stage

  ex_ctrl_stage u_ex_ctrl_stage (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .ex_valid (ex_valid),
    .ex_instr (ex_instr),
    .ex_ctrl  (ex_ctrl)
  );

  // Follows one stall-free edge behind
  wb_ctrl_stage u_wb_ctrl_stage (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .ex_valid (ex_valid),
    .ex_instr (ex_instr),
    .wb_valid (wb_valid),
    .wb_ctrl  (wb_ctrl)
  );

endmodule

`default_nettype wire

//--- tb/rv_ctrl_checker.sv
// ==============================
// Bound into rv_ctrl_pipe.
// Needs assertions enabled in the simulator.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  stall,
  input logic                  ex_valid,
  input rv_ctrl_pkg::ex_ctrl_t ex_ctrl,
  input logic                  wb_valid,
  input rv_ctrl_pkg::wb_ctrl_t wb_ctrl
);

  // Idle stages show no controls
  a_ex_idle_zero: assert property (@(posedge clk) disable iff (rst)
    !ex_valid |-> (ex_ctrl == '0))
    else $error("ex_ctrl is not zero while ex_valid is low");

  a_wb_idle_zero: assert property (@(posedge clk) disable iff (rst)
    !wb_valid |-> (wb_ctrl == '0))
    else $error("wb_ctrl is not zero while wb_valid is low");

  a_stall_hold: assert property (@(posedge clk)
    (!rst && stall) |=> ($stable(ex_valid) && $stable(ex_ctrl) &&
                         $stable(wb_valid) && $stable(wb_ctrl)))
    else $error("Outputs changed across a stalled edge");

  a_wb_follows_ex: assert property (@(posedge clk)
    (!rst && !stall) |=> (wb_valid == $past(ex_valid)))
    else $error("wb_valid does not follow the previous ex_valid");

endmodule

bind rv_ctrl_pipe rv_ctrl_checker u_checker (
  .clk      (clk),
  .rst      (rst),
  .stall    (stall),
  .ex_valid (ex_valid),
  .ex_ctrl  (ex_ctrl),
  .wb_valid (wb_valid),
  .wb_ctrl  (wb_ctrl)
);

`default_nettype wire

//--- tb/rv_ctrl_model.svh
// ==============================
// Reference decode and two-slot pipeline model.
// Include inside the testbench module, after the package import.
// ==============================
`ifndef RV_CTRL_MODEL_SVH
`define RV_CTRL_MODEL_SVH

logic        m_ex_valid;  // Execute slot
logic [31:0] m_ex_word;
logic        m_wb_valid;  // Writeback slot
logic [31:0] m_wb_word;

function automatic ex_ctrl_t model_ex_decode(input logic [31:0] w);
  ex_ctrl_t   c;
  logic [6:0] opc;
  logic [2:0] f3;
  logic       alt;
  opc = w[6:0];
  f3  = w[14:12];
  alt = (opc == OPC_RTYPE) ? (w[31:25] == F7_ALT) : w[30];  // Bit 30 marks srai
  c   = '0;
  if (opc == OPC_RTYPE || opc == OPC_ITYPE) begin
    case (f3)
      3'd0:    c.alu_op = (alt && opc == OPC_RTYPE) ? ALU_SUB : ALU_ADD;
      3'd1:    c.alu_op = ALU_SLL;
      3'd2:    c.alu_op = ALU_SLT;
      3'd3:    c.alu_op = ALU_SLTU;
      3'd4:    c.alu_op = ALU_XOR;
      3'd5:    c.alu_op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    c.alu_op = ALU_OR;
      default: c.alu_op = ALU_AND;
    endcase
  end
  c.a_pc  = (opc == OPC_JAL) || (opc == OPC_AUIPC);
  c.b_imm = (opc == OPC_ITYPE) || (opc == OPC_LOAD) || (opc == OPC_STORE) ||
            (opc == OPC_LUI) || c.a_pc;
  c.br_un = (opc == OPC_BRANCH) && (f3 == 3'd6 || f3 == 3'd7);  // BLTU, BGEU
  return c;
endfunction

function automatic wb_ctrl_t model_wb_decode(input logic [31:0] w);
  wb_ctrl_t c;
  c = '0;  // WB_MEM, LD_W and PC_PLUS4 all encode as zero
  case (w[6:0])
    OPC_RTYPE, OPC_ITYPE, OPC_AUIPC, OPC_LUI: begin
      c.rf_we  = 1'b1;
      c.wb_sel = WB_ALU;
    end
    OPC_LOAD: begin
      c.rf_we = 1'b1;
      case (w[14:12])
        3'd0:    c.ld_sel = LD_B;
        3'd1:    c.ld_sel = LD_H;
        3'd4:    c.ld_sel = LD_BU;
        3'd5:    c.ld_sel = LD_HU;
        default: c.ld_sel = LD_W;
      endcase
    end
    OPC_JAL, OPC_JALR: begin
      c.rf_we  = 1'b1;
      c.wb_sel = WB_PC4;
      c.pc_sel = PC_JUMP;
    end
    default: c.rf_we = 1'b0;
  endcase
  return c;
endfunction

// One rising edge of the pipeline registers
task automatic model_step(input logic r, input logic st, input logic v,
                          input logic [31:0] w);
  if (r) begin
    m_ex_valid = 1'b0;
    m_wb_valid = 1'b0;
  end else if (!st) begin
    m_wb_valid = m_ex_valid;
    m_wb_word  = m_ex_word;
    m_ex_valid = v;
    m_ex_word  = w;
  end
endtask

`endif

//--- tb/tb_rv_ctrl_pipe.sv
// ==============================
// Random stimulus from a fixed seed, checked each cycle against the model.
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ctrl_pipe;

  import rv_ctrl_pkg::*;

  localparam int NUM_CYCLES  = 3000;
  localparam int DRAIN_LIMIT = 20;

  logic      clk;
  logic      rst;
  logic      stall;
  logic      in_valid;
  rv_instr_u in_instr;
  logic      ex_valid;
  ex_ctrl_t  ex_ctrl;
  logic      wb_valid;
  wb_ctrl_t  wb_ctrl;

  int seed;
  int ex_errors;
  int wb_errors;
  int timeouts;

  `include "rv_ctrl_model.svh"

  rv_ctrl_pipe u_dut (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .ex_valid (ex_valid),
    .ex_ctrl  (ex_ctrl),
    .wb_valid (wb_valid),
    .wb_ctrl  (wb_ctrl)
  );

  always #4 clk = ~clk;  // 8 ns period

  // Mostly known opcodes, funct7 forced to the alternate code now and then
  task automatic make_instr(output rv_instr_u w);
    logic [31:0] raw;
    int          pick;
    raw  = $random(seed);
    pick = {$random(seed)} % 10;
    case (pick)
      0:       raw[6:0] = OPC_RTYPE;
      1:       raw[6:0] = OPC_ITYPE;
      2:       raw[6:0] = OPC_LOAD;
      3:       raw[6:0] = OPC_STORE;
      4:       raw[6:0] = OPC_BRANCH;
      5:       raw[6:0] = OPC_JAL;
      6:       raw[6:0] = OPC_JALR;
      7:       raw[6:0] = OPC_AUIPC;
      8:       raw[6:0] = OPC_LUI;
      default: raw[6:0] = raw[6:0];  // Fully random word
    endcase
    if (({$random(seed)} % 3) == 0) begin
      raw[31:25] = F7_ALT;
    end
    w = raw;
  endtask

  task automatic drive_random();
    rv_instr_u w;
    make_instr(w);
    in_instr = w;
    in_valid = ({$random(seed)} % 10) < 7;  // About 70 %
    stall    = ({$random(seed)} % 10) < 2;  // About 20 %
  endtask

  task automatic check_outputs();
    ex_ctrl_t exp_ex;
    wb_ctrl_t exp_wb;
    exp_ex = '0;
    exp_wb = '0;
    if (m_ex_valid) begin
      exp_ex = model_ex_decode(m_ex_word);
    end
    if (m_wb_valid) begin
      exp_wb = model_wb_decode(m_wb_word);
    end
    assert (ex_valid === m_ex_valid) else begin
      $display("ERR %0t: ex_valid got %b expected %b", $time, ex_valid, m_ex_valid);
      ex_errors++;
    end
    assert (ex_ctrl === exp_ex) else begin
      $display("ERR %0t: ex_ctrl got %h expected %h (word %h)", $time, ex_ctrl, exp_ex,
               m_ex_word);
      ex_errors++;
    end
    assert (wb_valid === m_wb_valid) else begin
      $display("ERR %0t: wb_valid got %b expected %b", $time, wb_valid, m_wb_valid);
      wb_errors++;
    end
    assert (wb_ctrl === exp_wb) else begin
      $display("ERR %0t: wb_ctrl got %h expected %h (word %h)", $time, wb_ctrl, exp_wb,
               m_wb_word);
      wb_errors++;
    end
  endtask

  // Inputs are untouched until 1 ns after the edge, so the model sees what the DUT saw
  task automatic step_and_check();
    @(posedge clk);
    model_step(rst, stall, in_valid, in_instr);
    #1;
    check_outputs();
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while ((ex_valid || wb_valid) && n < limit) begin
      step_and_check();
      n++;
    end
    if (ex_valid || wb_valid) begin
      $display("Timeout: pipeline still holds a valid instruction after %0d cycles", limit);
      timeouts++;
    end
  endtask

  initial begin
    seed      = 65;
    ex_errors = 0;
    wb_errors = 0;
    timeouts  = 0;
    clk       = 1'b0;
    rst       = 1'b1;
    stall     = 1'b0;
    in_valid  = 1'b0;
    in_instr  = '0;
    repeat (2) step_and_check();
    rst = 1'b0;
    repeat (3) step_and_check();  // Idle after reset
    for (int i = 0; i < NUM_CYCLES; i++) begin
      drive_random();
      step_and_check();
    end
    stall    = 1'b0;
    in_valid = 1'b0;
    wait_idle(DRAIN_LIMIT);
    $display("Errors: ex %0d, wb %0d, timeouts %0d", ex_errors, wb_errors, timeouts);
    if (ex_errors == 0 && wb_errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+tb
rtl/rv_ctrl_pkg.sv
rtl/ex_ctrl_stage.sv
rtl/wb_ctrl_stage.sv
rtl/rv_ctrl_pipe.sv
tb/rv_ctrl_checker.sv
tb/tb_rv_ctrl_pipe.sv

//--- Makefile
# Verilator flow for the RV32I control pipeline
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_rv_ctrl_pipe
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
BUILD_JOBS ?= 0
VFLAGS     ?= --timing --assert
PASS_MSG   ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(BUILD_JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
